/* br_defs.svh */
`ifndef BR_DEFS_SVH
`define BR_DEFS_SVH

// integer register and operand width.
`define BR_XLEN 64

// program counter and branch target width.
`define BR_PC_W 64

// reorder buffer id width.
`define BR_ROBID_W 6

// entries in the branch issue queue.
// 2, 4 and 8 are all supported.
`define BR_IQ_DEPTH 4

`endif

/* br_exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "br_defs.svh"

module br_exec_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    // issue side.
    input  wire logic                      iss_req,
    input  wire instr_pkg::uop_e           iss_uop,
    input  wire instr_pkg::br_funct_e      iss_funct3,
    input  wire logic [`BR_PC_W-1:0]       iss_pc,
    input  wire logic [`BR_XLEN-1:0]       iss_imm,
    input  wire logic [`BR_XLEN-1:0]       iss_src1,
    input  wire logic [`BR_XLEN-1:0]       iss_src2,
    input  wire logic [`BR_ROBID_W-1:0]    iss_robid,
    output logic                           iss_ack,

    // result side.
    input  wire logic                      res_ack,
    output logic                           res_req,
    output logic [`BR_XLEN-1:0]            res_result,
    output logic                           res_mispred,
    output logic [`BR_PC_W-1:0]            res_target,
    output logic [`BR_ROBID_W-1:0]         res_robid
);

    exec_pkg::iss_pkt_t iss_pkt;
    exec_pkg::br_res_t  res_pkt;

    br_stage_if #(.data_t(exec_pkg::iss_pkt_t)) iq_if ();
    br_stage_if #(.data_t(exec_pkg::br_res_t))  res_if ();

    // gather the flat inputs into an issue packet.
    assign iss_pkt.uinstr.uop    = iss_uop;
    assign iss_pkt.uinstr.funct3 = iss_funct3;
    assign iss_pkt.uinstr.pc     = iss_pc;
    assign iss_pkt.uinstr.imm    = iss_imm;
    assign iss_pkt.robid         = iss_robid;
    assign iss_pkt.src1          = iss_src1;
    assign iss_pkt.src2          = iss_src2;

    br_issue_q u_issue_q (
        .clk     (clk),
        .rst_n   (rst_n),
        .iss_req (iss_req),
        .iss_pkt (iss_pkt),
        .iss_ack (iss_ack),
        .deq     (iq_if.producer)
    );

    ibr u_ibr (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (iq_if.consumer),
        .res   (res_if.producer)
    );

    br_result_tx u_result_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .res_ack (res_ack),
        .res     (res_if.consumer),
        .res_req (res_req),
        .res_pkt (res_pkt)
    );

    // flatten the outgoing result.
    assign res_result  = res_pkt.result;
    assign res_mispred = res_pkt.mispred.valid;
    assign res_target  = res_pkt.mispred.target;
    assign res_robid   = res_pkt.mispred.robid;

endmodule

`default_nettype wire

/* br_golden.txt */
// uop funct3 pc imm src1 src2 robid | expect result mispred target robid
// non-branch lines carry expect 0 and zero expected fields.
2 0 1000 40 5 5 01 1 1004 1 1040 01
2 0 1004 40 5 6 02 1 1008 0 1008 02
2 1 1008 fffffffffffffff0 1 2 03 1 100c 1 0ff8 03
2 1 100c 20 7 7 04 1 1010 0 1010 04
2 4 1010 100 ffffffffffffffff 1 05 1 1014 1 1110 05
2 4 1014 100 1 ffffffffffffffff 06 1 1018 0 1018 06
2 5 1018 8 1 8000000000000000 07 1 101c 1 1020 07
2 5 101c 8 8000000000000000 0 08 1 1020 0 1020 08
2 6 1020 60 1 ffffffffffffffff 09 1 1024 1 1080 09
2 6 1024 60 ffffffffffffffff 1 0a 1 1028 0 1028 0a
2 7 1028 30 8000000000000000 7fffffffffffffff 0b 1 102c 1 1058 0b
2 7 102c 30 7fffffffffffffff 8000000000000000 0c 1 1030 0 1030 0c
1 0 1030 10 3 4 0d 0 0 0 0 0
3 0 1034 200 0 0 0e 1 1038 1 1234 0e
3 0 1038 4 0 0 0f 1 103c 0 103c 0f
0 0 103c 0 0 0 10 0 0 0 0 0
4 0 1040 5 2000 0 11 1 1044 1 2004 11
4 0 1044 fffffffffffffffd 3000 0 12 1 1048 1 2ffc 12
4 0 1048 1 104c 0 13 1 104c 0 104c 13
2 0 104c fffffffffffffffc 0 0 3f 1 1050 1 1048 3f
1 0 1050 0 9 9 14 0 0 0 0 0
2 7 1054 1c 55 55 2a 1 1058 1 1070 2a
2 4 1058 1c 9 9 15 1 105c 0 105c 15

/* br_issue_q.sv */
`timescale 1ns/1ns
`default_nettype none

`include "br_defs.svh"

module br_issue_q (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                iss_req,
    input  wire exec_pkg::iss_pkt_t  iss_pkt,
    output logic                     iss_ack,
    br_stage_if.producer             deq
);

    localparam int DEPTH = `BR_IQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ACK_HIGH,
        RX_WAIT_REQ_LOW
    } rx_state_e;

    rx_state_e          rx_state;
    exec_pkg::iss_pkt_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               push;
    logic               pop;

    assign full = (count == CNT_W'(DEPTH));
    assign push = (rx_state == RX_IDLE) && iss_req && !full;  // new request only from idle.
    assign pop  = deq.valid && deq.ready;

    assign iss_ack = (rx_state != RX_IDLE);

    // four-phase receive.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state <= RX_IDLE;
        end else begin
            case (rx_state)
                RX_IDLE: begin
                    if (push) rx_state <= RX_ACK_HIGH;  // a full queue leaves req waiting.
                end
                RX_ACK_HIGH: begin
                    if (!iss_req) rx_state <= RX_IDLE;
                    else          rx_state <= RX_WAIT_REQ_LOW;
                end
                RX_WAIT_REQ_LOW: begin
                    if (!iss_req) rx_state <= RX_IDLE;  // ack drops on this edge.
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // circular buffer pointers and occupancy.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

    // entry storage.
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= iss_pkt;
    end

    assign deq.valid = (count != '0);
    assign deq.data  = mem[rd_ptr];  // head of queue.

endmodule

`default_nettype wire

/* br_result_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module br_result_tx (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            res_ack,
    br_stage_if.consumer         res,
    output logic                 res_req,
    output exec_pkg::br_res_t    res_pkt
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ_HIGH,
        TX_WAIT_ACK_LOW
    } tx_state_e;

    tx_state_e         tx_state;
    exec_pkg::br_res_t hold;
    logic              take;

    // a new result is taken only once the previous exchange is closed.
    assign res.ready = (tx_state == TX_IDLE);
    assign take      = res.valid && res.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= TX_IDLE;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    if (take) tx_state <= TX_REQ_HIGH;
                end
                TX_REQ_HIGH: begin
                    if (res_ack) tx_state <= TX_WAIT_ACK_LOW;  // drop req.
                end
                TX_WAIT_ACK_LOW: begin
                    if (!res_ack) tx_state <= TX_IDLE;
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // holding register for the packet on the wire.
    always_ff @(posedge clk) begin
        if (take) hold <= res.data;
    end

    assign res_req = (tx_state == TX_REQ_HIGH);
    assign res_pkt = hold;  // stable for the whole exchange.

endmodule

`default_nettype wire

/* br_stage_if.sv */
`timescale 1ns/1ns
`default_nettype none

// valid/ready link between pipeline stages.
// a transfer happens on a clock edge with valid and ready both high.
interface br_stage_if #(
    parameter type data_t = logic
) ();

    logic  valid;
    logic  ready;
    data_t data;   // held stable while valid waits for ready.

    modport producer (
        output valid,
        output data,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

`include "br_defs.svh"

package exec_pkg;

    typedef logic [`BR_ROBID_W-1:0] robid_t;

    // issued micro-op with its source values already read.
    typedef struct packed {
        instr_pkg::uinstr_t uinstr;
        robid_t             robid;
        instr_pkg::xlen_t   src1;
        instr_pkg::xlen_t   src2;
    } iss_pkt_t;

    // redirect request toward the front end.
    // the front end always predicted fall through.
    typedef struct packed {
        logic           valid;
        instr_pkg::pc_t target;  // true next pc.
        robid_t         robid;
    } mispred_t;

    // resolved branch leaving the cluster.
    typedef struct packed {
        instr_pkg::xlen_t result;   // link value pc+4.
        mispred_t         mispred;
    } br_res_t;

endpackage

`default_nettype wire

/* files.f */
+incdir+.
instr_pkg.sv
exec_pkg.sv
br_stage_if.sv
br_issue_q.sv
ibr.sv
br_result_tx.sv
br_exec_top.sv
tb_br_exec.sv

/* ibr.sv */
`timescale 1ns/1ns
`default_nettype none

module ibr (
    input  wire logic    clk,
    input  wire logic    rst_n,
    br_stage_if.consumer iss,
    br_stage_if.producer res
);

    instr_pkg::uinstr_t uinstr_ex0;
    instr_pkg::xlen_t   src1_ex0;
    instr_pkg::xlen_t   src2_ex0;
    instr_pkg::pc_t     pcnxt_ex0;
    instr_pkg::pc_t     tkn_tgt_ex0;
    instr_pkg::pc_t     tru_tgt_ex0;
    logic               tkn_ex0;
    logic               isbr_ex0;
    exec_pkg::br_res_t  res_ex0;

    logic               ex1_vld;
    exec_pkg::br_res_t  ex1_res;

    assign uinstr_ex0 = iss.data.uinstr;
    assign src1_ex0   = iss.data.src1;
    assign src2_ex0   = iss.data.src2;
    assign isbr_ex0   = instr_pkg::is_branch(uinstr_ex0.uop);

    // EX0 condition evaluation.
    always_comb begin
        tkn_ex0 = 1'b0;
        case (uinstr_ex0.uop)
            instr_pkg::U_BR: begin
                case (uinstr_ex0.funct3)
                    instr_pkg::BR_BEQ:  tkn_ex0 = (src1_ex0 == src2_ex0);
                    instr_pkg::BR_BNE:  tkn_ex0 = (src1_ex0 != src2_ex0);
                    instr_pkg::BR_BLT:  tkn_ex0 = ($signed(src1_ex0) <  $signed(src2_ex0));
                    instr_pkg::BR_BGE:  tkn_ex0 = ($signed(src1_ex0) >= $signed(src2_ex0));
                    instr_pkg::BR_BLTU: tkn_ex0 = (src1_ex0 <  src2_ex0);
                    instr_pkg::BR_BGEU: tkn_ex0 = (src1_ex0 >= src2_ex0);
                    default:            tkn_ex0 = 1'b0;  // reserved funct3.
                endcase
            end
            instr_pkg::U_JAL, instr_pkg::U_JALR: tkn_ex0 = 1'b1;
            default:                             tkn_ex0 = 1'b0;
        endcase
    end

    // JALR targets are register relative with bit 0 cleared.
    always_comb begin
        if (uinstr_ex0.uop == instr_pkg::U_JALR) begin
            tkn_tgt_ex0 = instr_pkg::pc_t'(src1_ex0 + uinstr_ex0.imm) & ~instr_pkg::pc_t'(1);
        end else begin
            tkn_tgt_ex0 = uinstr_ex0.pc + instr_pkg::pc_t'(uinstr_ex0.imm);
        end
    end

    assign pcnxt_ex0   = uinstr_ex0.pc + instr_pkg::pc_t'(4);  // no compressed ops.
    assign tru_tgt_ex0 = tkn_ex0 ? tkn_tgt_ex0 : pcnxt_ex0;

    assign res_ex0.result         = instr_pkg::xlen_t'(pcnxt_ex0);
    assign res_ex0.mispred.valid  = (tru_tgt_ex0 != pcnxt_ex0);  // predicted fall through.
    assign res_ex0.mispred.target = tru_tgt_ex0;
    assign res_ex0.mispred.robid  = iss.data.robid;

    // EX1 accepts when empty or draining this cycle.
    assign iss.ready = !ex1_vld || res.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex1_vld <= 1'b0;
        end else if (iss.ready) begin
            ex1_vld <= iss.valid && isbr_ex0;  // non-branches just drop out.
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid && iss.ready && isbr_ex0) ex1_res <= res_ex0;
    end

    assign res.valid = ex1_vld;
    assign res.data  = ex1_res;

endmodule

`default_nettype wire

/* instr_pkg.sv */
`default_nettype none

`include "br_defs.svh"

package instr_pkg;

    typedef logic [`BR_XLEN-1:0] xlen_t;  // operand and link data.
    typedef logic [`BR_PC_W-1:0] pc_t;    // pc and targets.

    // micro-op classes seen by the execute cluster.
    typedef enum logic [2:0] {
        U_NOP  = 3'd0,
        U_ALU  = 3'd1,
        U_BR   = 3'd2,  // conditional branch.
        U_JAL  = 3'd3,
        U_JALR = 3'd4
    } uop_e;

    // branch conditions in funct3 encoding.
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd4,
        BR_BGE  = 3'd5,
        BR_BLTU = 3'd6,
        BR_BGEU = 3'd7
    } br_funct_e;

    // decoded micro-op as delivered by rename and issue.
    typedef struct packed {
        uop_e      uop;
        br_funct_e funct3;  // only meaningful for U_BR.
        pc_t       pc;
        xlen_t     imm;     // already sign extended.
    } uinstr_t;

    // true for anything the branch unit resolves.
    function automatic logic is_branch(input uop_e uop);
        logic br;
        br = 1'b0;
        case (uop)
            U_BR, U_JAL, U_JALR: br = 1'b1;
            default:             br = 1'b0;
        endcase
        return br;
    endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the branch execution cluster testbench with verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module tb_br_exec \
    -f files.f \
    -o tb_br_exec

./obj_dir/tb_br_exec | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"

/* tb_br_exec.sv */
`timescale 1ns/1ns
`default_nettype none

`include "br_defs.svh"

module tb_br_exec;

    localparam int NUM_OPS        = 23;
    localparam int WORDS_PER_OP   = 12;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int QUIET_CYCLES   = 40;

    // word offsets within one golden line.
    localparam int F_UOP     = 0;
    localparam int F_FUNCT3  = 1;
    localparam int F_PC      = 2;
    localparam int F_IMM     = 3;
    localparam int F_SRC1    = 4;
    localparam int F_SRC2    = 5;
    localparam int F_ROBID   = 6;
    localparam int F_EXPECT  = 7;
    localparam int F_RESULT  = 8;
    localparam int F_MISPRED = 9;
    localparam int F_TARGET  = 10;
    localparam int F_EROBID  = 11;

    logic                   clk;
    logic                   rst_n;
    logic                   iss_req;
    instr_pkg::uop_e        iss_uop;
    instr_pkg::br_funct_e   iss_funct3;
    logic [`BR_PC_W-1:0]    iss_pc;
    logic [`BR_XLEN-1:0]    iss_imm;
    logic [`BR_XLEN-1:0]    iss_src1;
    logic [`BR_XLEN-1:0]    iss_src2;
    logic [`BR_ROBID_W-1:0] iss_robid;
    logic                   iss_ack;
    logic                   res_ack;
    logic                   res_req;
    logic [`BR_XLEN-1:0]    res_result;
    logic                   res_mispred;
    logic [`BR_PC_W-1:0]    res_target;
    logic [`BR_ROBID_W-1:0] res_robid;

    logic [63:0] golden [0:NUM_OPS*WORDS_PER_OP-1];
    int          value_errors;
    int          other_errors;
    int          num_expected;
    int          num_responses;
    int          stalls_seen;   // issue requests that found the queue full.
    bit          aborted;
    int unsigned rng_state;

    br_exec_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss_req     (iss_req),
        .iss_uop     (iss_uop),
        .iss_funct3  (iss_funct3),
        .iss_pc      (iss_pc),
        .iss_imm     (iss_imm),
        .iss_src1    (iss_src1),
        .iss_src2    (iss_src2),
        .iss_robid   (iss_robid),
        .iss_ack     (iss_ack),
        .res_ack     (res_ack),
        .res_req     (res_req),
        .res_result  (res_result),
        .res_mispred (res_mispred),
        .res_target  (res_target),
        .res_robid   (res_robid)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period.

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // all driving and sampling happens 2 ns after the rising edge.
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic issue_op(input int idx);
        int base;
        int cycles;
        base       = idx * WORDS_PER_OP;
        iss_uop    = instr_pkg::uop_e'(golden[base+F_UOP][2:0]);
        iss_funct3 = instr_pkg::br_funct_e'(golden[base+F_FUNCT3][2:0]);
        iss_pc     = golden[base+F_PC];
        iss_imm    = golden[base+F_IMM];
        iss_src1   = golden[base+F_SRC1];
        iss_src2   = golden[base+F_SRC2];
        iss_robid  = golden[base+F_ROBID][`BR_ROBID_W-1:0];
        iss_req    = 1'b1;
        tick();
        cycles = 1;
        while (!iss_ack && cycles < TIMEOUT_CYCLES) begin
            tick();
            cycles++;
        end
        iss_req = 1'b0;
        if (!iss_ack) begin
            $display("error: op %0d never got iss_ack, timeout at %0t", idx, $time);
            other_errors++;
            aborted = 1'b1;
        end else begin
            if (cycles > 1) stalls_seen++;  // ack held back by a full queue.
            cycles = 0;
            while (iss_ack && cycles < TIMEOUT_CYCLES) begin
                tick();
                cycles++;
            end
            if (iss_ack) begin
                $display("error: iss_ack stuck high after op %0d at %0t", idx, $time);
                other_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic issue_all();
        for (int i = 0; i < NUM_OPS; i++) begin
            if (!aborted) issue_op(i);
        end
    endtask

    task automatic collect_responses();
        int          idx;
        int          base;
        int          cycles;
        int unsigned delay;
        idx = 0;
        while (num_responses < num_expected && !aborted) begin
            while (idx < NUM_OPS && golden[idx*WORDS_PER_OP+F_EXPECT][0] == 1'b0) idx++;
            base   = idx * WORDS_PER_OP;
            cycles = 0;
            while (!res_req && cycles < TIMEOUT_CYCLES) begin
                tick();
                cycles++;
            end
            if (!res_req) begin
                $display("error: no result request for op %0d, timeout at %0t", idx, $time);
                other_errors++;
                aborted = 1'b1;
            end else begin
                assert (res_result === golden[base+F_RESULT]) else begin
                    $display("FAILED at %0t: op %0d result %h, expected %h",
                             $time, idx, res_result, golden[base+F_RESULT]);
                    value_errors++;
                end
                assert (res_mispred === golden[base+F_MISPRED][0]) else begin
                    $display("FAILED at %0t: op %0d mispredict %b, expected %b",
                             $time, idx, res_mispred, golden[base+F_MISPRED][0]);
                    value_errors++;
                end
                assert (res_target === golden[base+F_TARGET]) else begin
                    $display("FAILED at %0t: op %0d target %h, expected %h",
                             $time, idx, res_target, golden[base+F_TARGET]);
                    value_errors++;
                end
                assert (res_robid === golden[base+F_EROBID][`BR_ROBID_W-1:0]) else begin
                    $display("FAILED at %0t: op %0d robid %h, expected %h",
                             $time, idx, res_robid, golden[base+F_EROBID][`BR_ROBID_W-1:0]);
                    value_errors++;
                end
                num_responses++;
                idx++;
                rng_state = lcg_next(rng_state);
                delay     = (rng_state >> 16) % 6;  // 0 to 5 cycles of ack delay.
                repeat (delay) begin
                    tick();
                    assert (res_req === 1'b1) else begin
                        $display("error: res_req dropped before res_ack at %0t", $time);
                        other_errors++;
                    end
                end
                res_ack = 1'b1;
                cycles  = 0;
                while (res_req && cycles < TIMEOUT_CYCLES) begin
                    tick();
                    cycles++;
                end
                if (res_req) begin
                    $display("error: res_req never fell after res_ack at %0t", $time);
                    other_errors++;
                    aborted = 1'b1;
                end
                res_ack = 1'b0;
            end
        end
    endtask

    // nothing more may come out once every flagged line has answered.
    task automatic check_quiet();
        repeat (QUIET_CYCLES) begin
            tick();
            assert (res_req === 1'b0) else begin
                $display("error: extra result request at %0t", $time);
                other_errors++;
            end
        end
    endtask

    initial begin
        int i;
        rst_n         = 1'b0;
        iss_req       = 1'b0;
        iss_uop       = instr_pkg::U_NOP;
        iss_funct3    = instr_pkg::BR_BEQ;
        iss_pc        = '0;
        iss_imm       = '0;
        iss_src1      = '0;
        iss_src2      = '0;
        iss_robid     = '0;
        res_ack       = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        num_responses = 0;
        stalls_seen   = 0;
        aborted       = 1'b0;
        rng_state     = 54;
        $readmemh("br_golden.txt", golden);
        num_expected = 0;
        for (i = 0; i < NUM_OPS; i++) begin
            if (golden[i*WORDS_PER_OP+F_EXPECT][0]) num_expected++;
        end

        repeat (8) @(posedge clk);
        #2;
        assert (iss_ack === 1'b0 && res_req === 1'b0) else begin
            $display("FAILED at %0t: handshake outputs high during reset", $time);
            value_errors++;
        end
        rst_n = 1'b1;
        tick();
        assert (iss_ack === 1'b0 && res_req === 1'b0) else begin
            $display("FAILED at %0t: handshake outputs high after reset", $time);
            value_errors++;
        end

        fork
            issue_all();
            collect_responses();
        join
        if (!aborted) check_quiet();

        assert (stalls_seen > 0) else begin
            $display("error: the issue queue never held back iss_ack");
            other_errors++;
        end

        $display("value errors %0d, other errors %0d, responses %0d of %0d, stalls %0d",
                 value_errors, other_errors, num_responses, num_expected, stalls_seen);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
